// File: src/pipe_pkg.sv
// Shared widths, opcodes, operand source codes and freeze timing for the
// integer pipeline slice. Every design file refers to these definitions by
// scoped name.

`default_nettype none

package pipe_pkg;

	// Data path and register file geometry
	localparam int WORD_W   = 32;
	localparam int IMM_W    = 16;
	localparam int REG_AW   = 4;
	localparam int NUM_REGS = 1 << REG_AW;
	localparam int SEL_W    = 2;
	localparam int COUNT_W  = 3;

	// Freeze lengths
	localparam int MUL_CYCLES   = 3;
	localparam int STALL_CYCLES = 4;

	typedef logic [WORD_W-1:0]  word_t;
	typedef logic [IMM_W-1:0]   imm_t;
	typedef logic [REG_AW-1:0]  reg_addr_t;
	typedef logic [COUNT_W-1:0] count_t;

	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_ADDI = 3'd5,
		OP_MUL  = 3'd6
	} opcode_t;

	// Operand source codes shared by the hazard compare and the operand muxes
	typedef enum logic [SEL_W-1:0] {
		SEL_RF  = 2'd0,
		SEL_IMM = 2'd1,
		SEL_EX  = 2'd2,
		SEL_WB  = 2'd3
	} sel_t;

	typedef enum logic [1:0] {
		FS_RUN   = 2'd0,
		FS_MUL   = 2'd1,
		FS_STALL = 2'd2
	} freeze_state_t;

endpackage

`default_nettype wire

// File: src/operand_if.sv
// Bundle of every candidate operand value and the two source-select codes.
// Register file, execute stage and hazard compare drive it through the
// source modport; the operand stage reads it all through sink.

`default_nettype none

interface operand_if;

	pipe_pkg::word_t rf_data_a;
	pipe_pkg::word_t rf_data_b;
	// Combinational ALU result of the instruction in EX
	pipe_pkg::word_t ex_forw;
	// Result held in the WB register
	pipe_pkg::word_t wb_forw;
	// Sign-extended ID immediate, driven from the top
	pipe_pkg::word_t simm;
	pipe_pkg::sel_t  sel_a;
	pipe_pkg::sel_t  sel_b;

	modport source (output rf_data_a, rf_data_b, ex_forw, wb_forw, sel_a, sel_b);
	modport sink (input rf_data_a, rf_data_b, ex_forw, wb_forw, simm, sel_a, sel_b);

endinterface

`default_nettype wire

// File: src/reg_file.sv
// General purpose register file, 16 words of 32 bits.
// Two combinational read ports feed the operand bundle; the single write
// port is fed from WB. A write is seen by reads from the next cycle on.

`default_nettype none

module reg_file (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire pipe_pkg::reg_addr_t rd_addr_a,
	input  wire pipe_pkg::reg_addr_t rd_addr_b,
	input  wire logic                wr_en,
	input  wire pipe_pkg::reg_addr_t wr_addr,
	input  wire pipe_pkg::word_t     wr_data,
	operand_if.source                ops
);

	pipe_pkg::word_t regs [pipe_pkg::NUM_REGS];

	// Register array, whole file cleared on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// Register 0 is hardwired to zero
	assign ops.rf_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign ops.rf_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: src/forward_select.sv
// Decode-stage hazard compare.
// Checks each ID source register against the EX and WB destinations and
// emits the operand source codes. EX is younger, so it wins over WB.

`default_nettype none

module forward_select (
	input  wire pipe_pkg::opcode_t   id_op,
	input  wire pipe_pkg::reg_addr_t id_ra,
	input  wire pipe_pkg::reg_addr_t id_rb,
	input  wire logic                ex_valid,
	input  wire pipe_pkg::reg_addr_t ex_rd,
	input  wire logic                wb_valid,
	input  wire pipe_pkg::reg_addr_t wb_rd,
	operand_if.source                ops
);

	// Source code for one register operand
	function automatic pipe_pkg::sel_t pick_src(input pipe_pkg::reg_addr_t src);
		pipe_pkg::sel_t sel;
		sel = pipe_pkg::SEL_RF;
		// r0 always comes from the file, which reads zero
		if (src != '0) begin
			if (ex_valid && (ex_rd == src)) begin
				sel = pipe_pkg::SEL_EX;
			end else if (wb_valid && (wb_rd == src)) begin
				sel = pipe_pkg::SEL_WB;
			end
		end
		return sel;
	endfunction

	assign ops.sel_a = pick_src(id_ra);

	// ADDI takes the immediate, whatever rb happens to hold
	assign ops.sel_b = (id_op == pipe_pkg::OP_ADDI) ? pipe_pkg::SEL_IMM : pick_src(id_rb);

endmodule

`default_nettype wire

// File: src/operand_muxes.sv
// Operand source muxes and the ID-to-EX operand registers.
// When only ID is frozen the registers capture the selected values once and
// keep them until both stages run again, so the held instruction enters EX
// with operands that were correct when it was first seen in ID.

`default_nettype none

module operand_muxes (
	input  wire logic            clk,
	input  wire logic            reset,
	input  wire logic            id_freeze,
	input  wire logic            ex_freeze,
	operand_if.sink              ops,
	output      pipe_pkg::word_t operand_a,
	output      pipe_pkg::word_t operand_b
);

	// Index 0 is operand A, index 1 is operand B
	pipe_pkg::word_t muxed [2];
	pipe_pkg::word_t oper  [2];
	logic [1:0]      saved;

	// One source mux, immediate only allowed where imm_ok is set
	function automatic pipe_pkg::word_t src_mux(
		input pipe_pkg::sel_t  sel,
		input pipe_pkg::word_t rf_data,
		input logic            imm_ok
	);
		pipe_pkg::word_t val;
		case (sel)
			pipe_pkg::SEL_EX:  val = ops.ex_forw;
			pipe_pkg::SEL_WB:  val = ops.wb_forw;
			pipe_pkg::SEL_IMM: val = imm_ok ? ops.simm : rf_data;
			default:           val = rf_data;
		endcase
		return val;
	endfunction

	assign muxed[0] = src_mux(ops.sel_a, ops.rf_data_a, 1'b0);
	assign muxed[1] = src_mux(ops.sel_b, ops.rf_data_b, 1'b1);

	////////////////////////////////////////////////////////////////////////////
	// Operand registers with save-on-ID-freeze
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 2; i++) begin
				oper[i] <= '0;
			end
			saved <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (!ex_freeze && !saved[i]) begin
					oper[i] <= muxed[i];
					// First cycle of an ID-only freeze, keep this value
					if (id_freeze) begin
						saved[i] <= 1'b1;
					end
				end else if (!ex_freeze && !id_freeze) begin
					saved[i] <= 1'b0;
				end
			end
		end
	end

	assign operand_a = oper[0];
	assign operand_b = oper[1];

endmodule

`default_nettype wire

// File: src/exec_stage.sv
// Execute stage and WB register.
// Holds the EX control fields, computes the ALU result from the registered
// operands and latches it into WB. Both results are fed back for forwarding.

`default_nettype none

module exec_stage (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                id_freeze,
	input  wire logic                ex_freeze,
	input  wire logic                id_valid,
	input  wire pipe_pkg::opcode_t   id_op,
	input  wire pipe_pkg::reg_addr_t id_rd,
	input  wire pipe_pkg::word_t     operand_a,
	input  wire pipe_pkg::word_t     operand_b,
	output      logic                ex_valid_out,
	output      pipe_pkg::opcode_t   ex_op_out,
	output      pipe_pkg::reg_addr_t ex_rd_out,
	operand_if.source                ops,
	output      logic                wb_valid,
	output      pipe_pkg::reg_addr_t wb_rd,
	output      pipe_pkg::word_t     wb_data
);

	pipe_pkg::word_t alu_out;

	// EX control, bubble when only ID is frozen, hold when EX is frozen
	always_ff @(posedge clk) begin
		if (reset) begin
			ex_valid_out <= 1'b0;
		end else if (!ex_freeze) begin
			ex_valid_out <= id_valid && !id_freeze;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze && !id_freeze) begin
			ex_op_out <= id_op;
			ex_rd_out <= id_rd;
		end
	end

	// ALU, all arithmetic wraps at 32 bits
	always_comb begin
		case (ex_op_out)
			pipe_pkg::OP_SUB: alu_out = operand_a - operand_b;
			pipe_pkg::OP_AND: alu_out = operand_a & operand_b;
			pipe_pkg::OP_OR:  alu_out = operand_a | operand_b;
			pipe_pkg::OP_XOR: alu_out = operand_a ^ operand_b;
			pipe_pkg::OP_MUL: alu_out = operand_a * operand_b;
			default:          alu_out = operand_a + operand_b;
		endcase
	end

	// WB register, gets a bubble while EX is frozen
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex_valid_out && !ex_freeze;
		end
	end

	always_ff @(posedge clk) begin
		if (!ex_freeze) begin
			wb_rd   <= ex_rd_out;
			wb_data <= alu_out;
		end
	end

	assign ops.ex_forw = alu_out;
	assign ops.wb_forw = wb_data;

endmodule

`default_nettype wire

// File: src/freeze_ctrl.sv
// Freeze controller.
// A MUL reaching EX freezes ID and EX together until the timer expires;
// a stall request freezes only ID for a fixed number of cycles.

`default_nettype none

module freeze_ctrl (
	input  wire logic              clk,
	input  wire logic              reset,
	input  wire logic              ex_valid,
	input  wire pipe_pkg::opcode_t ex_op,
	input  wire logic              stall_req,
	input  wire logic              timer_done,
	output      logic              timer_load,
	output      pipe_pkg::count_t  timer_value,
	output      logic              id_freeze,
	output      logic              ex_freeze
);

	pipe_pkg::freeze_state_t state;
	pipe_pkg::freeze_state_t state_nxt;
	logic                    counted;
	logic                    mul_start;

	// New MUL in EX, freeze starts in this same cycle
	assign mul_start = (state == pipe_pkg::FS_RUN) && ex_valid &&
		(ex_op == pipe_pkg::OP_MUL) && !counted;

	always_comb begin
		state_nxt   = state;
		timer_load  = 1'b0;
		timer_value = '0;
		case (state)
			pipe_pkg::FS_RUN: begin
				if (mul_start) begin
					timer_load  = 1'b1;
					timer_value = pipe_pkg::count_t'(pipe_pkg::MUL_CYCLES - 1);
					state_nxt   = pipe_pkg::FS_MUL;
				end else if (stall_req) begin
					timer_load  = 1'b1;
					timer_value = pipe_pkg::count_t'(pipe_pkg::STALL_CYCLES);
					state_nxt   = pipe_pkg::FS_STALL;
				end
			end
			pipe_pkg::FS_MUL, pipe_pkg::FS_STALL: begin
				if (timer_done) begin
					state_nxt = pipe_pkg::FS_RUN;
				end
			end
			default: state_nxt = pipe_pkg::FS_RUN;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= pipe_pkg::FS_RUN;
			counted <= 1'b0;
		end else begin
			state <= state_nxt;
			// Marks the MUL in EX as already timed until EX moves on
			if (mul_start) begin
				counted <= 1'b1;
			end else if (!ex_freeze) begin
				counted <= 1'b0;
			end
		end
	end

	// MUL releases EX in the timer's last cycle so it leaves on that edge
	assign ex_freeze = mul_start || ((state == pipe_pkg::FS_MUL) && !timer_done);
	assign id_freeze = ex_freeze || (state == pipe_pkg::FS_STALL);

endmodule

`default_nettype wire

// File: src/stall_timer.sv
// Down-counter for freeze lengths.
// Loaded by the freeze controller; done marks the last counted cycle.

`default_nettype none

module stall_timer (
	input  wire logic             clk,
	input  wire logic             reset,
	input  wire logic             load,
	input  wire pipe_pkg::count_t value,
	output      logic             done
);

	// Zero means idle
	pipe_pkg::count_t count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= value;
		end else if (count != '0) begin
			count <= count - pipe_pkg::count_t'(1);
		end
	end

	// Count of one is the last counted cycle
	assign done = (count == pipe_pkg::count_t'(1));

endmodule

`default_nettype wire

// File: src/pipe_core_top.sv
// Top of the integer pipeline slice.
// Accepts one instruction per cycle on plain ports when ready is high, holds
// it in the ID register and wires up operand selection, execute, WB and the
// freeze logic. Results leave on the wb_* ports as one-cycle strobes.

`default_nettype none

module pipe_core_top (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                instr_valid,
	input  wire pipe_pkg::opcode_t   instr_op,
	input  wire pipe_pkg::reg_addr_t instr_rd,
	input  wire pipe_pkg::reg_addr_t instr_ra,
	input  wire pipe_pkg::reg_addr_t instr_rb,
	input  wire pipe_pkg::imm_t      instr_imm,
	input  wire logic                stall_req,
	output      logic                ready,
	output      logic                wb_valid,
	output      pipe_pkg::reg_addr_t wb_rd,
	output      pipe_pkg::word_t     wb_data
);

	// ID stage instruction
	logic                id_valid;
	pipe_pkg::opcode_t   id_op;
	pipe_pkg::reg_addr_t id_rd;
	pipe_pkg::reg_addr_t id_ra;
	pipe_pkg::reg_addr_t id_rb;
	pipe_pkg::imm_t      id_imm;

	logic                id_freeze;
	logic                ex_freeze;
	logic                ex_valid;
	pipe_pkg::opcode_t   ex_op;
	pipe_pkg::reg_addr_t ex_rd;
	pipe_pkg::word_t     operand_a;
	pipe_pkg::word_t     operand_b;
	logic                timer_load;
	pipe_pkg::count_t    timer_value;
	logic                timer_done;

	operand_if ops ();

	assign ready = !id_freeze;

	////////////////////////////////////////////////////////////////////////////
	// ID register, empties when it passes to EX with nothing new accepted
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			id_valid <= 1'b0;
		end else if (!id_freeze) begin
			id_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (!id_freeze && instr_valid) begin
			id_op  <= instr_op;
			id_rd  <= instr_rd;
			id_ra  <= instr_ra;
			id_rb  <= instr_rb;
			id_imm <= instr_imm;
		end
	end

	assign ops.simm = {{(pipe_pkg::WORD_W - pipe_pkg::IMM_W){id_imm[pipe_pkg::IMM_W-1]}}, id_imm};

	reg_file u_reg_file (
		.clk       (clk),
		.reset     (reset),
		.rd_addr_a (id_ra),
		.rd_addr_b (id_rb),
		.wr_en     (wb_valid),
		.wr_addr   (wb_rd),
		.wr_data   (wb_data),
		.ops       (ops.source)
	);

	forward_select u_forward_select (
		.id_op    (id_op),
		.id_ra    (id_ra),
		.id_rb    (id_rb),
		.ex_valid (ex_valid),
		.ex_rd    (ex_rd),
		.wb_valid (wb_valid),
		.wb_rd    (wb_rd),
		.ops      (ops.source)
	);

	operand_muxes u_operand_muxes (
		.clk       (clk),
		.reset     (reset),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.ops       (ops.sink),
		.operand_a (operand_a),
		.operand_b (operand_b)
	);

	exec_stage u_exec_stage (
		.clk          (clk),
		.reset        (reset),
		.id_freeze    (id_freeze),
		.ex_freeze    (ex_freeze),
		.id_valid     (id_valid),
		.id_op        (id_op),
		.id_rd        (id_rd),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.ex_valid_out (ex_valid),
		.ex_op_out    (ex_op),
		.ex_rd_out    (ex_rd),
		.ops          (ops.source),
		.wb_valid     (wb_valid),
		.wb_rd        (wb_rd),
		.wb_data      (wb_data)
	);

	freeze_ctrl u_freeze_ctrl (
		.clk         (clk),
		.reset       (reset),
		.ex_valid    (ex_valid),
		.ex_op       (ex_op),
		.stall_req   (stall_req),
		.timer_done  (timer_done),
		.timer_load  (timer_load),
		.timer_value (timer_value),
		.id_freeze   (id_freeze),
		.ex_freeze   (ex_freeze)
	);

	stall_timer u_stall_timer (
		.clk   (clk),
		.reset (reset),
		.load  (timer_load),
		.value (timer_value),
		.done  (timer_done)
	);

endmodule

`default_nettype wire

// File: verification/pipe_core_checker.sv
// Result checker for the pipeline slice.
// Watches the DUT ports, runs an architectural register model on every
// accepted instruction and compares each retired result in program order.
// Also watches ready so that a MUL drops it and no freeze outlasts the
// stall length.

`default_nettype none

module pipe_core_checker (
	input  wire logic                clk,
	input  wire logic                reset,
	input  wire logic                instr_valid,
	input  wire pipe_pkg::opcode_t   instr_op,
	input  wire pipe_pkg::reg_addr_t instr_rd,
	input  wire pipe_pkg::reg_addr_t instr_ra,
	input  wire pipe_pkg::reg_addr_t instr_rb,
	input  wire pipe_pkg::imm_t      instr_imm,
	input  wire logic                ready,
	input  wire logic                wb_valid,
	input  wire pipe_pkg::reg_addr_t wb_rd,
	input  wire pipe_pkg::word_t     wb_data,
	input  var  int                  test_num,
	input  wire logic                test_last,
	output      int                  check_count,
	output      int                  error_count,
	output      int                  pending
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TEST_SLOTS = 8;

	// Architectural state updated in program order at accept
	pipe_pkg::word_t     model_regs [pipe_pkg::NUM_REGS];
	pipe_pkg::word_t     exp_data [$];
	pipe_pkg::reg_addr_t exp_rd [$];
	int                  exp_test [$];
	logic                exp_last [$];
	// MUL flag and ready-low count taken at accept
	logic                exp_mul [$];
	int                  exp_low [$];
	int                  test_checks [TEST_SLOTS];
	int                  test_errors [TEST_SLOTS];
	int                  ready_low_run;
	int                  ready_low_total;

	// Architectural result of one instruction
	function automatic pipe_pkg::word_t expected_result(
		input pipe_pkg::opcode_t op,
		input pipe_pkg::word_t   a,
		input pipe_pkg::word_t   b,
		input pipe_pkg::imm_t    imm
	);
		pipe_pkg::word_t simm;
		pipe_pkg::word_t res;
		simm = {{16{imm[15]}}, imm};
		case (op)
			pipe_pkg::OP_ADD:  res = a + b;
			pipe_pkg::OP_SUB:  res = a - b;
			pipe_pkg::OP_AND:  res = a & b;
			pipe_pkg::OP_OR:   res = a | b;
			pipe_pkg::OP_XOR:  res = a ^ b;
			pipe_pkg::OP_ADDI: res = a + simm;
			default:           res = a * b;
		endcase
		return res;
	endfunction

	function automatic pipe_pkg::word_t read_model(input pipe_pkg::reg_addr_t r);
		return (r == '0) ? '0 : model_regs[r];
	endfunction

	always @(posedge clk) begin
		pipe_pkg::word_t     res;
		pipe_pkg::word_t     want_data;
		pipe_pkg::reg_addr_t want_rd;
		int                  t;
		logic                last;
		logic                was_mul;
		int                  low_at_accept;
		if (reset) begin
			for (int i = 0; i < pipe_pkg::NUM_REGS; i++) begin
				model_regs[i] = '0;
			end
			for (int i = 0; i < TEST_SLOTS; i++) begin
				test_checks[i] = 0;
				test_errors[i] = 0;
			end
			check_count     = 0;
			error_count     = 0;
			pending         <= 0;
			ready_low_run   = 0;
			ready_low_total = 0;
		end else begin
			// No freeze may hold ID longer than a stall
			if (!ready) begin
				ready_low_total = ready_low_total + 1;
				ready_low_run   = ready_low_run + 1;
				if (ready_low_run == pipe_pkg::STALL_CYCLES + 1) begin
					$display("Freeze too long: ready low for more than %0d cycles",
						pipe_pkg::STALL_CYCLES);
					error_count = error_count + 1;
				end
			end else begin
				ready_low_run = 0;
			end
			////////////////////////////////////////////////////////////////////////////
			// Retire side takes the oldest entry first
			////////////////////////////////////////////////////////////////////////////
			if (wb_valid) begin
				if (exp_data.size() == 0) begin
					$display("Unexpected result: wb_valid high with no instruction outstanding");
					error_count = error_count + 1;
				end else begin
					want_data     = exp_data.pop_front();
					want_rd       = exp_rd.pop_front();
					t             = exp_test.pop_front();
					last          = exp_last.pop_front();
					was_mul       = exp_mul.pop_front();
					low_at_accept = exp_low.pop_front();
					check_count = check_count + 1;
					test_checks[t] = test_checks[t] + 1;
					if (wb_rd !== want_rd) begin
						$display("FAIL test %0d: wb_rd got %h expected %h", t, wb_rd, want_rd);
						test_errors[t] = test_errors[t] + 1;
					end
					if (wb_data !== want_data) begin
						$display("FAIL test %0d: wb_data got %h expected %h",
							t, wb_data, want_data);
						test_errors[t] = test_errors[t] + 1;
					end
					if ((wb_rd !== want_rd) || (wb_data !== want_data)) begin
						error_count = error_count + 1;
					end
					// A MUL holds ID for its extra EX cycles on the way through
					if (was_mul &&
						((ready_low_total - low_at_accept) < pipe_pkg::MUL_CYCLES - 1)) begin
						$display("Missing freeze in test %0d: ready did not drop for a MUL", t);
						test_errors[t] = test_errors[t] + 1;
						error_count = error_count + 1;
					end
					// Last row of a test has retired
					if (last) begin
						$display("test %0d: %0d results checked, %0d mismatches",
							t, test_checks[t], test_errors[t]);
					end
				end
			end
			// Accept side runs the model with sequential semantics
			if (instr_valid && ready) begin
				res = expected_result(instr_op, read_model(instr_ra), read_model(instr_rb),
					instr_imm);
				if (instr_rd != '0) begin
					model_regs[instr_rd] = res;
				end
				exp_data.push_back(res);
				exp_rd.push_back(instr_rd);
				exp_test.push_back(test_num);
				exp_last.push_back(test_last);
				exp_mul.push_back(instr_op == pipe_pkg::OP_MUL);
				exp_low.push_back(ready_low_total);
			end
			pending <= exp_data.size();
		end
	end

endmodule

`default_nettype wire

// File: verification/pipe_core_tb.sv
// Testbench for the pipeline slice.
// Builds a table of instructions, applies it row by row on falling clock
// edges while honoring ready, and leaves all comparing to the checker.
// A cycle counter ends the run if results stop arriving.

`default_nettype none

module pipe_core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic                clk;
	logic                reset;
	logic                instr_valid;
	pipe_pkg::opcode_t   instr_op;
	pipe_pkg::reg_addr_t instr_rd;
	pipe_pkg::reg_addr_t instr_ra;
	pipe_pkg::reg_addr_t instr_rb;
	pipe_pkg::imm_t      instr_imm;
	logic                stall_req;
	logic                ready;
	logic                wb_valid;
	pipe_pkg::reg_addr_t wb_rd;
	pipe_pkg::word_t     wb_data;

	int   cur_test;
	logic cur_last;
	int   check_count;
	int   error_count;
	int   pending;

	// Stimulus table with one entry per instruction
	int                  row_test [$];
	pipe_pkg::opcode_t   row_op [$];
	pipe_pkg::reg_addr_t row_rd [$];
	pipe_pkg::reg_addr_t row_ra [$];
	pipe_pkg::reg_addr_t row_rb [$];
	pipe_pkg::imm_t      row_imm [$];
	logic                row_stall [$];
	int                  row_gap [$];

	logic [31:0] lcg_state;
	int          cycle_count;
	int          cycle_limit;

	pipe_core_top UUT (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr_op    (instr_op),
		.instr_rd    (instr_rd),
		.instr_ra    (instr_ra),
		.instr_rb    (instr_rb),
		.instr_imm   (instr_imm),
		.stall_req   (stall_req),
		.ready       (ready),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data)
	);

	pipe_core_checker u_checker (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr_op    (instr_op),
		.instr_rd    (instr_rd),
		.instr_ra    (instr_ra),
		.instr_rb    (instr_rb),
		.instr_imm   (instr_imm),
		.ready       (ready),
		.wb_valid    (wb_valid),
		.wb_rd       (wb_rd),
		.wb_data     (wb_data),
		.test_num    (cur_test),
		.test_last   (cur_last),
		.check_count (check_count),
		.error_count (error_count),
		.pending     (pending)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic add_row(
		input int                  t,
		input pipe_pkg::opcode_t   op,
		input pipe_pkg::reg_addr_t rd,
		input pipe_pkg::reg_addr_t ra,
		input pipe_pkg::reg_addr_t rb,
		input pipe_pkg::imm_t      imm,
		input logic                stl,
		input int                  gap
	);
		row_test.push_back(t);
		row_op.push_back(op);
		row_rd.push_back(rd);
		row_ra.push_back(ra);
		row_rb.push_back(rb);
		row_imm.push_back(imm);
		row_stall.push_back(stl);
		row_gap.push_back(gap);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test table
	////////////////////////////////////////////////////////////////////////////

	task automatic build_table();
		// Test 1 reads r0 and never written registers, then loads LCG immediates
		for (int r = 1; r <= 4; r++) begin
			add_row(1, pipe_pkg::OP_ADD, 4'(r), 4'd0, 4'(r + 8), 16'h0, 1'b0, 0);
		end
		for (int r = 1; r <= 4; r++) begin
			add_row(1, pipe_pkg::OP_ADDI, 4'(r), 4'd0, 4'd0, 16'(lcg_next() >> 16), 1'b0, 0);
		end
		// Test 2 is a dependent chain over EX, WB and file paths
		add_row(2, pipe_pkg::OP_ADD, 4'd5, 4'd1, 4'd2, 16'h0, 1'b0, 0);
		add_row(2, pipe_pkg::OP_SUB, 4'd6, 4'd5, 4'd1, 16'h0, 1'b0, 0);
		add_row(2, pipe_pkg::OP_XOR, 4'd7, 4'd2, 4'd5, 16'h0, 1'b0, 0);
		add_row(2, pipe_pkg::OP_OR,  4'd8, 4'd6, 4'd7, 16'h0, 1'b0, 0);
		add_row(2, pipe_pkg::OP_AND, 4'd9, 4'd3, 4'd8, 16'h0, 1'b0, 1);
		add_row(2, pipe_pkg::OP_ADD, 4'd0, 4'd1, 4'd2, 16'h0, 1'b0, 0);
		add_row(2, pipe_pkg::OP_ADD, 4'd10, 4'd0, 4'd0, 16'h0, 1'b0, 0);
		add_row(2, pipe_pkg::OP_SUB, 4'd10, 4'd9, 4'd4, 16'h0, 1'b0, 0);
		// Test 3 has ADDI with rb matching a pending destination
		add_row(3, pipe_pkg::OP_ADDI, 4'd11, 4'd10, 4'd10, 16'h8001, 1'b0, 0);
		add_row(3, pipe_pkg::OP_ADDI, 4'd12, 4'd11, 4'd11, 16'h0123, 1'b0, 0);
		// Test 4 is MUL followed by dependents
		add_row(4, pipe_pkg::OP_MUL, 4'd13, 4'd1, 4'd2, 16'h0, 1'b0, 0);
		add_row(4, pipe_pkg::OP_ADD, 4'd14, 4'd13, 4'd1, 16'h0, 1'b0, 0);
		add_row(4, pipe_pkg::OP_MUL, 4'd15, 4'd14, 4'd13, 16'h0, 1'b0, 0);
		add_row(4, pipe_pkg::OP_SUB, 4'd1, 4'd15, 4'd14, 16'h0, 1'b0, 0);
		add_row(4, pipe_pkg::OP_XOR, 4'd2, 4'd1, 4'd15, 16'h0, 1'b0, 0);
		// Test 5 stalls with a dependent in ID and sends a second pulse into FS_STALL
		add_row(5, pipe_pkg::OP_ADD, 4'd3, 4'd1, 4'd2, 16'h0, 1'b0, 0);
		add_row(5, pipe_pkg::OP_ADD, 4'd4, 4'd3, 4'd1, 16'h0, 1'b1, 0);
		add_row(5, pipe_pkg::OP_SUB, 4'd5, 4'd4, 4'd3, 16'h0, 1'b1, 0);
		add_row(5, pipe_pkg::OP_OR,  4'd6, 4'd5, 4'd4, 16'h0, 1'b0, 0);
		// Test 6 is a random mix
		for (int k = 0; k < 24; k++) begin
			add_row(6, pipe_pkg::opcode_t'((lcg_next() >> 16) % 7),
				4'(lcg_next() >> 20), 4'(lcg_next() >> 20), 4'(lcg_next() >> 20),
				16'(lcg_next() >> 16), ((lcg_next() >> 16) % 6) == 0,
				int'((lcg_next() >> 16) % 3));
		end
	endtask

	// Called and returns on a falling edge
	task automatic apply_row(input int i);
		instr_valid = 1'b1;
		instr_op    = row_op[i];
		instr_rd    = row_rd[i];
		instr_ra    = row_ra[i];
		instr_rb    = row_rb[i];
		instr_imm   = row_imm[i];
		stall_req   = row_stall[i];
		cur_test    = row_test[i];
		cur_last    = (i == row_test.size() - 1) || (row_test[i+1] != row_test[i]);
		// Instruction held while ready is low
		// Stall pulse lasts one cycle
		while (!ready) begin
			@(negedge clk);
			stall_req = 1'b0;
		end
		@(negedge clk);
		instr_valid = 1'b0;
		stall_req   = 1'b0;
		repeat (row_gap[i]) @(negedge clk);
	endtask

	// Cycle limit scaled from the table length
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if ((cycle_limit > 0) && (cycle_count > cycle_limit)) begin
			$display("Timeout: results still outstanding after %0d cycles", cycle_limit);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		instr_valid = 1'b0;
		instr_op    = pipe_pkg::OP_ADD;
		instr_rd    = '0;
		instr_ra    = '0;
		instr_rb    = '0;
		instr_imm   = '0;
		stall_req   = 1'b0;
		cur_test    = 0;
		cur_last    = 1'b0;
		cycle_count = 0;
		lcg_state   = 32'h7614f3cf;
		build_table();
		cycle_limit = row_test.size() *
			(pipe_pkg::MUL_CYCLES + pipe_pkg::STALL_CYCLES + 4) + 20;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		for (int i = 0; i < row_test.size(); i++) begin
			apply_row(i);
		end
		// Drain and watch a few more cycles for stray strobes
		while (pending != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		$display("Results checked %0d, errors %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
src/pipe_pkg.sv
src/operand_if.sv
src/reg_file.sv
src/forward_select.sv
src/operand_muxes.sv
src/exec_stage.sv
src/freeze_ctrl.sv
src/stall_timer.sv
src/pipe_core_top.sv
verification/pipe_core_checker.sv
verification/pipe_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wall
TOP       ?= pipe_core_tb
RTL_TOP   ?= pipe_core_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
